// File: dphy_rx_pkg.sv
//****************************************
// D-PHY receive front end shared package
// Lane count, sync pattern, data types,
// APB register map and FSM state types
//****************************************
`default_nettype none

package dphy_rx_pkg;

  // Lane count and sync pattern of the HS burst
  localparam int DATA_LANES = 4;
  localparam logic [7:0] SYNC_BYTE = 8'hB8;

  typedef logic [7:0]              lane_byte_t;
  // Lane 0 sits in the low byte
  typedef logic [DATA_LANES*8-1:0] lane_word_t;
  typedef logic [DATA_LANES-1:0]   lane_mask_t;
  // Deskew delay of one lane, 0 to 2 cycles
  typedef logic [1:0]              delay_sel_t;
  typedef logic [7:0]              apb_addr_t;
  typedef logic [31:0]             apb_data_t;
  typedef logic [15:0]             event_cnt_t;

  // Register map
  localparam apb_addr_t REG_CTRL      = 8'h00;
  localparam apb_addr_t REG_STATUS    = 8'h04;
  localparam apb_addr_t REG_PKT_CNT   = 8'h08;
  localparam apb_addr_t REG_FALSE_CNT = 8'h0C;

  typedef enum logic {HUNT, LOCKED} align_state_t;
  typedef enum logic {IDLE, ACCESS} apb_state_t;

endpackage

`default_nettype wire

// File: dphy_byte_align.sv
//****************************************
// D-PHY lane byte aligner
// Finds the sync byte at any bit offset,
// locks on it and emits aligned bytes
//****************************************
`timescale 1ns/1ps
`default_nettype none

module dphy_byte_align
  import dphy_rx_pkg::*;
(
  input  wire logic       byte_clk_i,
  input  wire logic       rst_i,
  input  wire logic       enable_i,
  input  wire logic       sync_reset_i,
  input  wire lane_byte_t raw_byte_i,
  output lane_byte_t      byte_o,
  output logic            valid_o
);

  lane_byte_t   raw_q;
  lane_byte_t   prev_q;
  logic [15:0]  window;
  logic         hit;
  logic [2:0]   hit_ofs;
  logic [2:0]   offset_q;
  align_state_t state_q;

  // Deserialized bytes, current and previous
  always_ff @(posedge byte_clk_i)
  begin
    raw_q  <= raw_byte_i;
    prev_q <= raw_q;
  end

  // Current byte above the previous one
  assign window = {raw_q, prev_q};

  // Search offsets from high to low so the lowest match wins
  always_comb
  begin
    hit     = 1'b0;
    hit_ofs = 3'd0;
    for (int i = 7; i >= 0; i--)
    begin
      if (window[i +: 8] == SYNC_BYTE)
      begin
        hit     = 1'b1;
        hit_ofs = 3'(i);
      end
    end
  end

  // Hunt until sync is seen, then stay locked until a sync reset
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      state_q  <= HUNT;
      offset_q <= 3'd0;
    end
    else if (!enable_i || sync_reset_i)
    begin
      state_q <= HUNT;
    end
    else if (state_q == HUNT && hit)
    begin
      state_q  <= LOCKED;
      offset_q <= hit_ofs;
    end
  end

  // One cycle after the sync match the window holds the next byte
  assign byte_o  = window[offset_q +: 8];
  assign valid_o = (state_q == LOCKED);

endmodule

`default_nettype wire

// File: dphy_word_align.sv
//****************************************
// D-PHY word aligner
// Removes up to two cycles of lane skew,
// builds the word, flags packet start and
// resets the lanes on false start or end
//****************************************
`timescale 1ns/1ps
`default_nettype none

module dphy_word_align
  import dphy_rx_pkg::*;
(
  input  wire logic       byte_clk_i,
  input  wire logic       rst_i,
  input  wire logic       enable_i,
  input  wire logic       pkt_done_i,
  input  wire lane_word_t byte_data_i,
  input  wire lane_mask_t valid_i,
  output logic            sync_reset_o,
  output lane_word_t      word_o,
  output logic            word_valid_o,
  output logic            sop_o,
  output logic            pkt_running_o,
  output logic            false_start_o
);

  lane_word_t word_d1;
  lane_word_t word_d2;
  lane_word_t word_d3;
  lane_mask_t valid_d1;
  lane_mask_t valid_d2;
  lane_mask_t valid_d3;
  delay_sel_t sel_delay [DATA_LANES];
  delay_sel_t sel_delay_q [DATA_LANES];
  logic       all_lanes_valid;
  logic       one_lane_sync;
  logic       pkt_start;
  logic       pkt_running_q;

  // Lane data moves down the delay line every cycle
  always_ff @(posedge byte_clk_i)
  begin
    word_d1 <= byte_data_i;
    word_d2 <= word_d1;
    word_d3 <= word_d2;
  end

  // Valid history, flushed on sync reset so old valids do not restart a packet
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i || sync_reset_o || !enable_i)
    begin
      valid_d1 <= '0;
      valid_d2 <= '0;
      valid_d3 <= '0;
    end
    else
    begin
      valid_d1 <= valid_i;
      valid_d2 <= valid_d1;
      valid_d3 <= valid_d2;
    end
  end

  // All lanes valid, whatever their mutual skew
  assign all_lanes_valid = &valid_d1;

  // Some lane valid for three cycles in a row
  always_comb
  begin
    one_lane_sync = 1'b0;
    for (int i = 0; i < DATA_LANES; i++)
    begin
      if (valid_d1[i] && valid_d2[i] && valid_d3[i])
        one_lane_sync = 1'b1;
    end
  end

  // False start when that lane is still waiting for the others
  assign false_start_o = one_lane_sync && !all_lanes_valid;
  // Lanes go back to hunting on packet end or false start
  assign sync_reset_o  = pkt_done_i || false_start_o;
  assign pkt_start     = all_lanes_valid && !pkt_running_q && !sync_reset_o;

  // Earliest lane gets the longest delay, picked once per packet
  always_comb
  begin
    for (int i = 0; i < DATA_LANES; i++)
    begin
      sel_delay[i] = sel_delay_q[i];
      if (pkt_start)
      begin
        if (valid_d3[i])
          sel_delay[i] = 2'd2;
        else if (valid_d2[i])
          sel_delay[i] = 2'd1;
        else
          sel_delay[i] = 2'd0;
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < DATA_LANES; i++)
        sel_delay_q[i] <= 2'd0;
      pkt_running_q <= 1'b0;
      sop_o         <= 1'b0;
    end
    else
    begin
      for (int i = 0; i < DATA_LANES; i++)
        sel_delay_q[i] <= sel_delay[i];
      sop_o <= pkt_start;
      if (sync_reset_o)
        pkt_running_q <= 1'b0;
      else if (pkt_start)
        pkt_running_q <= 1'b1;
    end
  end

  // Output word, one cycle after the delay selection
  always_ff @(posedge byte_clk_i)
  begin
    for (int i = 0; i < DATA_LANES; i++)
    begin
      case (sel_delay[i])
        2'd2:    word_o[8*i +: 8] <= word_d3[8*i +: 8];
        2'd1:    word_o[8*i +: 8] <= word_d2[8*i +: 8];
        default: word_o[8*i +: 8] <= word_d1[8*i +: 8];
      endcase
    end
  end

  // Word stream runs exactly while the packet is running
  assign word_valid_o  = pkt_running_q;
  assign pkt_running_o = pkt_running_q;

endmodule

`default_nettype wire

// File: dphy_rx_regs.sv
//****************************************
// D-PHY receive APB register block
// Enable control, status and two
// saturating event counters
//****************************************
`timescale 1ns/1ps
`default_nettype none

module dphy_rx_regs
  import dphy_rx_pkg::*;
(
  input  wire logic      byte_clk_i,
  input  wire logic      rst_i,
  input  wire logic      psel_i,
  input  wire logic      penable_i,
  input  wire logic      pwrite_i,
  input  wire apb_addr_t paddr_i,
  input  wire apb_data_t pwdata_i,
  input  wire logic      sop_i,
  input  wire logic      pkt_running_i,
  input  wire logic      false_start_i,
  output apb_data_t      prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  output logic           enable_o
);

  apb_state_t state_q;
  event_cnt_t pkt_cnt_q;
  event_cnt_t false_cnt_q;
  logic       addr_hit;
  logic       wr_en;

  // Setup phase moves to access, access always returns to idle
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
      state_q <= IDLE;
    else if (state_q == IDLE && psel_i && !penable_i)
      state_q <= ACCESS;
    else
      state_q <= IDLE;
  end

  // No wait states, ready in the access cycle itself
  assign pready_o = (state_q == ACCESS) && psel_i && penable_i;

  always_comb
  begin
    addr_hit = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      REG_CTRL:      prdata_o = {31'd0, enable_o};
      REG_STATUS:    prdata_o = {31'd0, pkt_running_i};
      REG_PKT_CNT:   prdata_o = {16'd0, pkt_cnt_q};
      REG_FALSE_CNT: prdata_o = {16'd0, false_cnt_q};
      default:       addr_hit = 1'b0;
    endcase
  end

  assign pslverr_o = pready_o && !addr_hit;
  assign wr_en     = pready_o && pwrite_i;

  // Control bit and counters; a write to a counter clears it
  always_ff @(posedge byte_clk_i)
  begin
    if (rst_i)
    begin
      enable_o    <= 1'b0;
      pkt_cnt_q   <= '0;
      false_cnt_q <= '0;
    end
    else
    begin
      if (wr_en && paddr_i == REG_CTRL)
        enable_o <= pwdata_i[0];
      if (wr_en && paddr_i == REG_PKT_CNT)
        pkt_cnt_q <= '0;
      else if (sop_i && pkt_cnt_q != '1)
        pkt_cnt_q <= pkt_cnt_q + 1'b1;
      if (wr_en && paddr_i == REG_FALSE_CNT)
        false_cnt_q <= '0;
      else if (false_start_i && false_cnt_q != '1)
        false_cnt_q <= false_cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: dphy_rx_top.sv
//****************************************
// D-PHY four-lane receive front end
// Byte aligners, word aligner, registers
//****************************************
`timescale 1ns/1ps
`default_nettype none

module dphy_rx_top
  import dphy_rx_pkg::*;
(
  input  wire logic       byte_clk_i,
  input  wire logic       rst_i,
  input  wire lane_word_t raw_byte_i,
  input  wire logic       pkt_done_i,
  input  wire logic       psel_i,
  input  wire logic       penable_i,
  input  wire logic       pwrite_i,
  input  wire apb_addr_t  paddr_i,
  input  wire apb_data_t  pwdata_i,
  output lane_word_t      word_o,
  output logic            word_valid_o,
  output logic            sop_o,
  output apb_data_t       prdata_o,
  output logic            pready_o,
  output logic            pslverr_o
);

  logic       enable;
  logic       sync_reset;
  lane_word_t lane_bytes;
  lane_mask_t lane_valid;
  logic       pkt_running;
  logic       false_start;

  // One byte aligner per lane
  for (genvar g = 0; g < DATA_LANES; g++)
  begin : g_lane
    dphy_byte_align i_byte_align (
      .byte_clk_i   (byte_clk_i),
      .rst_i        (rst_i),
      .enable_i     (enable),
      .sync_reset_i (sync_reset),
      .raw_byte_i   (raw_byte_i[8*g +: 8]),
      .byte_o       (lane_bytes[8*g +: 8]),
      .valid_o      (lane_valid[g])
    );
  end

  dphy_word_align i_word_align (
    .byte_clk_i    (byte_clk_i),
    .rst_i         (rst_i),
    .enable_i      (enable),
    .pkt_done_i    (pkt_done_i),
    .byte_data_i   (lane_bytes),
    .valid_i       (lane_valid),
    .sync_reset_o  (sync_reset),
    .word_o        (word_o),
    .word_valid_o  (word_valid_o),
    .sop_o         (sop_o),
    .pkt_running_o (pkt_running),
    .false_start_o (false_start)
  );

  dphy_rx_regs i_regs (
    .byte_clk_i    (byte_clk_i),
    .rst_i         (rst_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .sop_i         (sop_o),
    .pkt_running_i (pkt_running),
    .false_start_i (false_start),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .enable_o      (enable)
  );

endmodule

`default_nettype wire

// File: tb_dphy_rx_asserts.sv
//****************************************
// Word aligner protocol assertions
// Packet start and sync reset rules
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_dphy_rx_asserts (
  input wire logic byte_clk_i,
  input wire logic rst_i,
  input wire logic sop_i,
  input wire logic word_valid_i,
  input wire logic sync_reset_i
);

  // Start of packet only with a valid word
  sop_with_valid: assert property (@(posedge byte_clk_i) disable iff (rst_i)
    sop_i |-> word_valid_i)
    else $error("sop without word valid");

  // Start of packet lasts one cycle
  sop_single: assert property (@(posedge byte_clk_i) disable iff (rst_i)
    sop_i |=> !sop_i)
    else $error("sop high for two cycles");

  // Sync reset ends the word stream
  sync_reset_stops: assert property (@(posedge byte_clk_i) disable iff (rst_i)
    sync_reset_i |=> !word_valid_i)
    else $error("word valid after sync reset");

endmodule

bind dphy_word_align tb_dphy_rx_asserts i_word_align_asserts (
  .byte_clk_i   (byte_clk_i),
  .rst_i        (rst_i),
  .sop_i        (sop_o),
  .word_valid_i (word_valid_o),
  .sync_reset_i (sync_reset_o)
);

`default_nettype wire

// File: tb_dphy_rx.sv
//****************************************
// D-PHY receive front end testbench
// Skewed bit-shifted lanes, APB access,
// word compare against a reference
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_dphy_rx
  import dphy_rx_pkg::*;
();

  localparam int PKT_LEN      = 16;
  localparam int IDLE_BYTES   = 4;
  localparam int STREAM_BYTES = IDLE_BYTES + 2 + 1 + PKT_LEN + 3;
  localparam int NUM_PKTS     = 6;
  localparam int WATCHDOG_CYC = NUM_PKTS * (PKT_LEN + 40);

  logic       byte_clk_i;
  logic       rst_i;
  lane_word_t raw_byte_i;
  logic       pkt_done_i;
  logic       psel_i;
  logic       penable_i;
  logic       pwrite_i;
  apb_addr_t  paddr_i;
  apb_data_t  pwdata_i;
  lane_word_t word_o;
  logic       word_valid_o;
  logic       sop_o;
  apb_data_t  prdata_o;
  logic       pready_o;
  logic       pslverr_o;

  // Line bits per lane with the earliest bit in bit 0
  logic [STREAM_BYTES*8-1:0] lane_bits [DATA_LANES];
  lane_byte_t payload [DATA_LANES][PKT_LEN];
  int         lane_skew [DATA_LANES];
  int         lane_ofs [DATA_LANES];
  int         seed;
  int         rx_count;
  int         sop_count;
  int         exp_len;
  int         mismatch_cnt;
  int         other_cnt;
  apb_data_t  rd_data;
  logic       rd_err;

  dphy_rx_top i_dut (.*);

  always #50 byte_clk_i = ~byte_clk_i;

  // Expected word k holds payload byte k of every lane with lane 0 low
  function automatic lane_word_t ref_word(int k);
    lane_word_t w;
    for (int l = 0; l < DATA_LANES; l++)
      w[8*l +: 8] = payload[l][k];
    return w;
  endfunction

  // Compare every valid word at mid-cycle
  always @(negedge byte_clk_i)
  begin
    if (!rst_i && word_valid_o)
    begin
      if (sop_o)
      begin
        sop_count++;
        assert (rx_count == 0)
        else
        begin
          $display("sop_o seen on word %0d instead of word 0", rx_count);
          other_cnt++;
        end
      end
      if (rx_count < exp_len)
      begin
        assert (word_o == ref_word(rx_count))
        else
        begin
          $display("mismatch word_o[%0d] exp %h got %h", rx_count, ref_word(rx_count), word_o);
          mismatch_cnt++;
        end
      end
      else
      begin
        $display("unexpected word %h after %0d expected words", word_o, exp_len);
        other_cnt++;
      end
      rx_count++;
    end
  end

  task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t data);
    @(negedge byte_clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = data;
    @(negedge byte_clk_i);
    penable_i = 1'b1;
    #10;
    // No wait states, so ready must be up now
    assert (pready_o)
    else
    begin
      $display("pready_o missing in access phase at address %h", addr);
      other_cnt++;
    end
    rd_data = prdata_o;
    rd_err  = pslverr_o;
    @(negedge byte_clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic check_reg(input apb_addr_t addr, input apb_data_t exp);
    apb_access(addr, 1'b0, '0);
    assert (rd_data == exp && !rd_err)
    else
    begin
      $display("mismatch prdata_o addr %h exp %h got %h err %h", addr, exp, rd_data, rd_err);
      mismatch_cnt++;
    end
  endtask

  task automatic pick_alignment(input logic rotate);
    logic [31:0] rnd;
    for (int l = 0; l < DATA_LANES; l++)
    begin
      rnd = $random(seed);
      // Rotation guarantees a skew different from the last packet
      if (rotate)
        lane_skew[l] = (lane_skew[l] + 1) % 3;
      else
        lane_skew[l] = int'(rnd % 32'd3);
      lane_ofs[l] = int'((rnd >> 8) & 32'd7);
    end
  endtask

  // Idle zeros, sync byte and payload shifted by skew and bit offset
  task automatic build_streams(input logic single_lane);
    logic [31:0] rnd;
    int p;
    for (int l = 0; l < DATA_LANES; l++)
    begin
      lane_bits[l] = '0;
      for (int k = 0; k < PKT_LEN; k++)
      begin
        rnd = $random(seed);
        payload[l][k] = single_lane ? 8'h5A : rnd[7:0];
      end
      if (!single_lane || l == 0)
      begin
        p = (IDLE_BYTES + lane_skew[l]) * 8 + lane_ofs[l];
        for (int j = 0; j < 8; j++)
          lane_bits[l][p + j] = SYNC_BYTE[j];
        for (int k = 0; k < PKT_LEN; k++)
          for (int j = 0; j < 8; j++)
            lane_bits[l][p + 8 + 8*k + j] = payload[l][k][j];
      end
    end
  endtask

  task automatic send_streams();
    for (int t = 0; t < STREAM_BYTES; t++)
    begin
      @(negedge byte_clk_i);
      for (int l = 0; l < DATA_LANES; l++)
        raw_byte_i[8*l +: 8] = lane_bits[l][8*t +: 8];
    end
    @(negedge byte_clk_i);
    raw_byte_i = '0;
  endtask

  // One packet where pkt_done follows the last expected word
  task automatic run_packet(input logic expect_words, input logic single_lane);
    build_streams(single_lane);
    exp_len   = expect_words ? PKT_LEN : 0;
    rx_count  = 0;
    sop_count = 0;
    fork
      send_streams();
      if (expect_words)
      begin
        // Status flag is up while words flow
        wait (rx_count == 1);
        check_reg(REG_STATUS, 32'd1);
        wait (rx_count == PKT_LEN);
        pkt_done_i = 1'b1;
        @(negedge byte_clk_i);
        pkt_done_i = 1'b0;
        assert (!word_valid_o)
        else
        begin
          $display("word_valid_o still high after pkt_done_i");
          other_cnt++;
        end
      end
    join
    repeat (8) @(negedge byte_clk_i);
    assert (sop_count == (expect_words ? 1 : 0))
    else
    begin
      $display("packet gave %0d sop pulses", sop_count);
      other_cnt++;
    end
  endtask

  // Watchdog sized from packet count and length
  initial
  begin
    #(WATCHDOG_CYC * 100);
    $display("watchdog expired, the run did not finish in time");
    $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    seed         = 32'h6cd6;
    mismatch_cnt = 0;
    other_cnt    = 0;
    exp_len      = 0;
    rx_count     = 0;
    sop_count    = 0;
    byte_clk_i   = 1'b0;
    rst_i        = 1'b1;
    raw_byte_i   = '0;
    pkt_done_i   = 1'b0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    paddr_i      = '0;
    pwdata_i     = '0;
    repeat (4) @(posedge byte_clk_i);
    @(negedge byte_clk_i);
    rst_i = 1'b0;

    // Enable readback and unmapped address
    apb_access(REG_CTRL, 1'b1, 32'd1);
    check_reg(REG_CTRL, 32'd1);
    apb_access(8'h10, 1'b0, '0);
    assert (rd_err)
    else
    begin
      $display("no pslverr_o for unmapped address 10");
      other_cnt++;
    end

    // Random skews and then a rotated skew after pkt_done
    pick_alignment(1'b0);
    run_packet(1'b1, 1'b0);
    pick_alignment(1'b0);
    run_packet(1'b1, 1'b0);
    pick_alignment(1'b1);
    run_packet(1'b1, 1'b0);
    check_reg(REG_PKT_CNT, 32'd3);
    check_reg(REG_STATUS, 32'd0);

    // False start on lane 0 and then a normal packet
    check_reg(REG_FALSE_CNT, 32'd0);
    run_packet(1'b0, 1'b1);
    check_reg(REG_FALSE_CNT, 32'd1);
    pick_alignment(1'b0);
    run_packet(1'b1, 1'b0);

    // Disabled receiver passes no words
    apb_access(REG_CTRL, 1'b1, 32'd0);
    check_reg(REG_CTRL, 32'd0);
    pick_alignment(1'b0);
    run_packet(1'b0, 1'b0);
    apb_access(REG_CTRL, 1'b1, 32'd1);

    check_reg(REG_PKT_CNT, 32'd4);
    apb_access(REG_PKT_CNT, 1'b1, 32'd0);
    check_reg(REG_PKT_CNT, 32'd0);

    $display("%0d mismatches, %0d other errors", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
dphy_rx_pkg.sv
dphy_byte_align.sv
dphy_word_align.sv
dphy_rx_regs.sv
dphy_rx_top.sv
tb_dphy_rx_asserts.sv
tb_dphy_rx.sv

// File: run.sh
#!/bin/sh
# Build and run the D-PHY receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f --top-module tb_dphy_rx -o sim_tb_dphy_rx
then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb_dphy_rx)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]
then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "TESTS PASSED"
then
  exit 0
fi
exit 1
